// File: rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // line and set geometry
    localparam int LEN_LINE  = 5;
    localparam int LEN_INDEX = 7;
    localparam int LEN_TAG   = 32 - LEN_LINE - LEN_INDEX;
    localparam int NR_SETS   = 1 << LEN_INDEX;
    localparam int NR_WORDS  = 1 << (LEN_LINE - 2);

    // read burst codes for a line refill
    localparam int BURST_LEN = NR_WORDS - 1;
    localparam int WORD_SIZE = 2;

    typedef logic [31:0]          addr_t;
    typedef logic [31:0]          word_t;
    typedef logic [LEN_TAG-1:0]   tag_t;
    typedef logic [LEN_INDEX-1:0] index_t;
    typedef logic [LEN_LINE-3:0]  offset_t;
    typedef logic                 way_t;

    // set index joined with word position
    typedef logic [LEN_INDEX+LEN_LINE-3:0] bank_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        REFILL,
        UNCACHED
    } refill_state_t;

endpackage

`default_nettype wire

// File: rtl/icache_beat_counter.sv
`default_nettype none

module icache_beat_counter (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                i_clear,
    input  wire logic                i_beat,
    input  wire icache_pkg::offset_t i_critical_pos,
    output icache_pkg::offset_t      o_beat_pos,
    output logic                     o_critical_beat
);
    import icache_pkg::*;

    // word position of the next beat
    offset_t beat_pos;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_pos <= '0;
        end else if (i_clear) begin
            beat_pos <= '0;
        end else if (i_beat) begin
            beat_pos <= beat_pos + 1'b1;
        end
    end

    assign o_beat_pos = beat_pos;

    // bursts start at word zero, so the position tells the beat directly
    assign o_critical_beat = (beat_pos == i_critical_pos);

endmodule

`default_nettype wire

// File: rtl/icache_tag_store.sv
`default_nettype none

module icache_tag_store (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               i_rd_en,
    input  wire icache_pkg::index_t i_rd_index,
    input  wire icache_pkg::tag_t   i_cmp_tag,
    input  wire logic               i_install,
    input  wire icache_pkg::way_t   i_install_way,
    input  wire icache_pkg::index_t i_wr_index,
    input  wire icache_pkg::tag_t   i_wr_tag,
    input  wire logic               i_touch,
    input  wire icache_pkg::way_t   i_touch_way,
    output logic                    o_hit,
    output icache_pkg::way_t        o_hit_way,
    output icache_pkg::way_t        o_victim_way
);
    import icache_pkg::*;

    tag_t   tag_ram_0 [NR_SETS];
    tag_t   tag_ram_1 [NR_SETS];
    tag_t   rd_tag_0;
    tag_t   rd_tag_1;
    index_t rd_index;

    // per-set state in flops, looked up at the stage-two index
    logic [NR_SETS-1:0] valid_0;
    logic [NR_SETS-1:0] valid_1;
    // set bit means way 1 is least recently used
    logic [NR_SETS-1:0] lru;

    logic hit_0;
    logic hit_1;

    always_ff @(posedge clk) begin
        if (i_install && i_install_way == 1'b0) begin
            tag_ram_0[i_wr_index] <= i_wr_tag;
        end
        if (i_rd_en) begin
            rd_tag_0 <= tag_ram_0[i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (i_install && i_install_way == 1'b1) begin
            tag_ram_1[i_wr_index] <= i_wr_tag;
        end
        if (i_rd_en) begin
            rd_tag_1 <= tag_ram_1[i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            rd_index <= i_rd_index;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_0 <= '0;
            valid_1 <= '0;
            lru     <= '0;
        end else if (i_install) begin
            if (i_install_way) begin
                valid_1[i_wr_index] <= 1'b1;
            end else begin
                valid_0[i_wr_index] <= 1'b1;
            end
            lru[i_wr_index] <= ~i_install_way;
        end else if (i_touch) begin
            // touch always refers to the set held in stage two
            lru[rd_index] <= ~i_touch_way;
        end
    end

    assign hit_0 = valid_0[rd_index] && (rd_tag_0 == i_cmp_tag);
    assign hit_1 = valid_1[rd_index] && (rd_tag_1 == i_cmp_tag);

    assign o_hit        = hit_0 || hit_1;
    assign o_hit_way    = hit_1;
    assign o_victim_way = o_hit ? o_hit_way : lru[rd_index];

endmodule

`default_nettype wire

// File: rtl/icache_data_bank.sv
`default_nettype none

module icache_data_bank (
    input  wire logic                   clk,
    input  wire logic                   i_rd_en,
    input  wire icache_pkg::bank_addr_t i_rd_addr,
    input  wire logic                   i_wr_en,
    input  wire icache_pkg::bank_addr_t i_wr_addr,
    input  wire icache_pkg::word_t      i_wr_data,
    output icache_pkg::word_t           o_rd_data
);
    import icache_pkg::*;

    localparam int DEPTH = NR_SETS * NR_WORDS;

    word_t mem [DEPTH];

    // simple dual port, old data on a same-address collision
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/icache_refill_fsm.sv
`default_nettype none

module icache_refill_fsm (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                i_advance,
    input  wire logic                i_req,
    input  wire logic                i_no_cache,
    input  wire logic                i_hit,
    input  wire icache_pkg::way_t    i_hit_way,
    input  wire icache_pkg::way_t    i_victim_way,
    input  wire icache_pkg::tag_t    i_tag,
    input  wire icache_pkg::index_t  i_index,
    input  wire icache_pkg::offset_t i_word_pos,
    input  wire logic                i_arready,
    input  wire logic                i_rvalid,
    input  wire logic                i_rlast,
    input  wire icache_pkg::word_t   i_rdata,
    input  wire logic                i_critical_beat,
    output logic                     o_arvalid,
    output icache_pkg::addr_t        o_araddr,
    output logic [7:0]               o_arlen,
    output logic [2:0]               o_arsize,
    output logic                     o_rready,
    output logic                     o_busy,
    output logic                     o_done,
    output icache_pkg::word_t        o_critical_word,
    output logic                     o_install,
    output logic                     o_touch,
    output icache_pkg::way_t         o_way,
    output logic [1:0]               o_bank_wr,
    output logic                     o_cnt_clear,
    output logic                     o_cnt_beat
);
    import icache_pkg::*;

    refill_state_t state;
    way_t          fill_way;
    logic          start;
    logic          start_uncached;
    logic          start_fill;
    logic          beat;
    logic          fill_beat;

    assign start          = (state == IDLE) && i_advance && i_req;
    assign start_uncached = start && i_no_cache;
    assign start_fill     = start && !i_no_cache && !i_hit;
    assign beat           = i_rvalid && o_rready;
    assign fill_beat      = (state == REFILL) && beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            o_arvalid <= 1'b0;
            o_rready  <= 1'b0;
            o_done    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_uncached) begin
                        o_arvalid <= 1'b1;
                        state     <= UNCACHED;
                    end else if (start_fill) begin
                        o_arvalid <= 1'b1;
                        state     <= REFILL;
                    end
                end
                REFILL: begin
                    if (o_arvalid && i_arready) begin
                        o_arvalid <= 1'b0;
                        o_rready  <= 1'b1;
                    end else if (beat && i_rlast) begin
                        o_rready <= 1'b0;
                    end else if (!o_arvalid && !o_rready) begin
                        // last beat is in the bank by now
                        state  <= IDLE;
                        o_done <= 1'b1;
                    end
                end
                UNCACHED: begin
                    if (o_arvalid && i_arready) begin
                        o_arvalid <= 1'b0;
                        o_rready  <= 1'b1;
                    end else if (beat) begin
                        o_rready <= 1'b0;
                        state    <= IDLE;
                        o_done   <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_uncached) begin
            o_araddr <= {i_tag, i_index, i_word_pos, 2'b00};
            o_arlen  <= 8'd0;
        end else if (start_fill) begin
            // whole line from word zero
            o_araddr <= {i_tag, i_index, {LEN_LINE{1'b0}}};
            o_arlen  <= 8'(BURST_LEN);
            fill_way <= i_victim_way;
        end
        if ((state == UNCACHED && beat) || (fill_beat && i_critical_beat)) begin
            o_critical_word <= i_rdata;
        end
    end

    assign o_arsize = 3'(WORD_SIZE);
    assign o_busy   = (state != IDLE);

    // tag store strobes act at the edge that leaves idle
    assign o_install = start_fill;
    assign o_touch   = start && !i_no_cache && i_hit;
    assign o_way     = (state == IDLE) ? (i_hit ? i_hit_way : i_victim_way) : fill_way;

    assign o_bank_wr   = {fill_way, !fill_way} & {2{fill_beat}};
    assign o_cnt_clear = start_fill;
    assign o_cnt_beat  = fill_beat;

endmodule

`default_nettype wire

// File: rtl/icache.sv
`default_nettype none

module icache (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              i_inst_en,
    input  wire icache_pkg::addr_t i_inst_addr,
    input  wire logic              i_no_cache,
    input  wire logic              i_stall_f2,
    output logic                   o_stall,
    output icache_pkg::word_t      o_inst_rdata,
    output icache_pkg::addr_t      o_araddr,
    output logic [7:0]             o_arlen,
    output logic [2:0]             o_arsize,
    output logic                   o_arvalid,
    input  wire logic              i_arready,
    output logic                   o_rready,
    input  wire icache_pkg::word_t i_rdata,
    input  wire logic              i_rlast,
    input  wire logic              i_rvalid
);
    import icache_pkg::*;

    tag_t       s1_tag;
    index_t     s1_index;
    offset_t    s1_word_pos;

    logic       s2_req;
    logic       s2_no_cache;
    tag_t       s2_tag;
    index_t     s2_index;
    offset_t    s2_word_pos;

    logic       advance;
    logic       served;
    logic       answered;
    logic       fsm_req;

    logic       hit;
    way_t       hit_way;
    way_t       victim_way;

    logic       busy;
    logic       done;
    logic       install;
    logic       touch;
    way_t       fsm_way;
    logic [1:0] bank_wr;
    logic       cnt_clear;
    logic       cnt_beat;
    offset_t    beat_pos;
    logic       critical_beat;
    word_t      critical_word;

    bank_addr_t rd_addr;
    bank_addr_t wr_addr;
    word_t      rd_data_0;
    word_t      rd_data_1;

    assign s1_tag      = i_inst_addr[31 -: LEN_TAG];
    assign s1_index    = i_inst_addr[LEN_LINE +: LEN_INDEX];
    assign s1_word_pos = i_inst_addr[2 +: LEN_LINE-2];

    assign advance = !i_stall_f2 || o_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_req      <= 1'b0;
            s2_no_cache <= 1'b0;
        end else if (advance) begin
            s2_req      <= i_inst_en;
            s2_no_cache <= i_no_cache;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s2_tag      <= s1_tag;
            s2_index    <= s1_index;
            s2_word_pos <= s1_word_pos;
        end
    end

    // captured word stays on the output until the core takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            served <= 1'b0;
        end else begin
            served <= (done || served) && !advance;
        end
    end

    assign answered = done || served;
    assign fsm_req  = s2_req && !answered;

    assign o_stall      = (busy || (s2_req && (s2_no_cache || !hit))) && !answered;
    assign o_inst_rdata = answered ? critical_word : (hit_way ? rd_data_1 : rd_data_0);

    assign rd_addr = {s1_index, s1_word_pos};
    // refill set comes from the issued address
    assign wr_addr = {o_araddr[LEN_LINE +: LEN_INDEX], beat_pos};

    icache_tag_store i_tag_store (
        .clk           (clk),
        .rst           (rst),
        .i_rd_en       (advance),
        .i_rd_index    (s1_index),
        .i_cmp_tag     (s2_tag),
        .i_install     (install),
        .i_install_way (fsm_way),
        .i_wr_index    (s2_index),
        .i_wr_tag      (s2_tag),
        .i_touch       (touch),
        .i_touch_way   (fsm_way),
        .o_hit         (hit),
        .o_hit_way     (hit_way),
        .o_victim_way  (victim_way)
    );

    icache_data_bank i_bank_0 (
        .clk       (clk),
        .i_rd_en   (advance),
        .i_rd_addr (rd_addr),
        .i_wr_en   (bank_wr[0]),
        .i_wr_addr (wr_addr),
        .i_wr_data (i_rdata),
        .o_rd_data (rd_data_0)
    );

    icache_data_bank i_bank_1 (
        .clk       (clk),
        .i_rd_en   (advance),
        .i_rd_addr (rd_addr),
        .i_wr_en   (bank_wr[1]),
        .i_wr_addr (wr_addr),
        .i_wr_data (i_rdata),
        .o_rd_data (rd_data_1)
    );

    icache_refill_fsm i_refill_fsm (
        .clk             (clk),
        .rst             (rst),
        .i_advance       (advance),
        .i_req           (fsm_req),
        .i_no_cache      (s2_no_cache),
        .i_hit           (hit),
        .i_hit_way       (hit_way),
        .i_victim_way    (victim_way),
        .i_tag           (s2_tag),
        .i_index         (s2_index),
        .i_word_pos      (s2_word_pos),
        .i_arready       (i_arready),
        .i_rvalid        (i_rvalid),
        .i_rlast         (i_rlast),
        .i_rdata         (i_rdata),
        .i_critical_beat (critical_beat),
        .o_arvalid       (o_arvalid),
        .o_araddr        (o_araddr),
        .o_arlen         (o_arlen),
        .o_arsize        (o_arsize),
        .o_rready        (o_rready),
        .o_busy          (busy),
        .o_done          (done),
        .o_critical_word (critical_word),
        .o_install       (install),
        .o_touch         (touch),
        .o_way           (fsm_way),
        .o_bank_wr       (bank_wr),
        .o_cnt_clear     (cnt_clear),
        .o_cnt_beat      (cnt_beat)
    );

    icache_beat_counter i_beat_counter (
        .clk             (clk),
        .rst             (rst),
        .i_clear         (cnt_clear),
        .i_beat          (cnt_beat),
        .i_critical_pos  (s2_word_pos),
        .o_beat_pos      (beat_pos),
        .o_critical_beat (critical_beat)
    );

endmodule

`default_nettype wire

// File: bench/axi_mem_model.sv
`default_nettype none

module axi_mem_model (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire icache_pkg::word_t i_pattern,
    input  wire icache_pkg::addr_t i_araddr,
    input  wire logic [7:0]        i_arlen,
    input  wire logic              i_arvalid,
    output logic                   o_arready,
    output icache_pkg::word_t      o_rdata,
    output logic                   o_rlast,
    output logic                   o_rvalid,
    input  wire logic              i_rready
);
    import icache_pkg::*;

    integer     seed = 7;
    logic       busy = 1'b0;
    logic       arready = 1'b0;
    logic       rvalid = 1'b0;
    logic       rlast = 1'b0;
    word_t      rdata = '0;
    addr_t      beat_addr = '0;
    logic [7:0] beats_left = '0;

    // word-aligned address xor pattern, rotated left by 7
    function automatic word_t beat_word(input addr_t addr, input word_t pattern);
        word_t x;
        x = {addr[31:2], 2'b00} ^ pattern;
        return {x[24:0], x[31:25]};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
        end else if (!busy) begin
            if (i_arvalid && arready) begin
                busy       <= 1'b1;
                arready    <= 1'b0;
                beat_addr  <= i_araddr;
                beats_left <= i_arlen;
            end else begin
                // ready toggles at random while idle
                arready <= ($random(seed) & 1) == 1;
            end
        end else if (rvalid) begin
            if (i_rready) begin
                rvalid     <= 1'b0;
                rlast      <= 1'b0;
                beat_addr  <= beat_addr + 32'd4;
                beats_left <= beats_left - 8'd1;
                if (rlast) begin
                    busy <= 1'b0;
                end
            end
        end else if (($random(seed) & 3) != 0) begin
            rvalid <= 1'b1;
            rdata  <= beat_word(beat_addr, i_pattern);
            rlast  <= (beats_left == 8'd0);
        end
    end

    assign o_arready = arready;
    assign o_rvalid  = rvalid;
    assign o_rlast   = rlast;
    assign o_rdata   = rdata;

endmodule

`default_nettype wire

// File: bench/tb_icache.sv
`default_nettype none

module tb_icache;
    import icache_pkg::*;

    localparam word_t PATTERN         = 32'h5A3C_96E1;
    localparam int    BP_REQUESTS     = 24;
    localparam int    RANDOM_REQUESTS = 400;
    localparam int    NR_REQUESTS     = 1 + 8 + 6 + 3 + BP_REQUESTS + RANDOM_REQUESTS;

    logic       clk = 1'b0;
    logic       rst;
    logic       inst_en;
    addr_t      inst_addr;
    logic       no_cache;
    logic       stall_f2;
    logic       stall;
    word_t      inst_rdata;
    addr_t      araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic       arvalid;
    logic       arready;
    logic       rready;
    word_t      rdata;
    logic       rlast;
    logic       rvalid;

    integer seed;
    int     error_count;

    // reference cache, lru set means way 1 is least recently used
    logic [19:0] ref_tag [2][128];
    bit          ref_valid [2][128];
    bit          ref_lru [128];

    string      exp_name [$];
    word_t      exp_word [$];
    addr_t      exp_addr [$];
    logic [7:0] exp_len [$];
    bit         exp_hit [$];

    bit pending;
    int xfers;
    int beats;
    int stalls;

    always #4 clk = ~clk;

    icache i_icache (
        .clk(clk), .rst(rst),
        .i_inst_en(inst_en), .i_inst_addr(inst_addr), .i_no_cache(no_cache),
        .i_stall_f2(stall_f2), .o_stall(stall), .o_inst_rdata(inst_rdata),
        .o_araddr(araddr), .o_arlen(arlen), .o_arsize(arsize), .o_arvalid(arvalid),
        .i_arready(arready), .o_rready(rready), .i_rdata(rdata), .i_rlast(rlast),
        .i_rvalid(rvalid)
    );

    axi_mem_model i_mem (
        .clk(clk), .rst(rst), .i_pattern(PATTERN),
        .i_araddr(araddr), .i_arlen(arlen), .i_arvalid(arvalid), .o_arready(arready),
        .o_rdata(rdata), .o_rlast(rlast), .o_rvalid(rvalid), .i_rready(rready)
    );

    function automatic word_t mem_word(input addr_t addr);
        word_t x;
        x = {addr[31:2], 2'b00} ^ PATTERN;
        return {x[24:0], x[31:25]};
    endfunction

    // predicts hit or miss and updates tags, valid and lru like the cache
    function automatic bit lookup(input addr_t addr, input bit nc);
        logic [6:0]  idx;
        logic [19:0] tag;
        bit          way;
        idx = addr[11:5];
        tag = addr[31:12];
        if (nc) return 1'b0;
        if (ref_valid[0][idx] && ref_tag[0][idx] == tag) begin
            ref_lru[idx] = 1'b1;
            return 1'b1;
        end
        if (ref_valid[1][idx] && ref_tag[1][idx] == tag) begin
            ref_lru[idx] = 1'b0;
            return 1'b1;
        end
        way = ref_lru[idx];
        ref_tag[way][idx] = tag;
        ref_valid[way][idx] = 1'b1;
        ref_lru[idx] = !way;
        return 1'b0;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic abort(input string what);
        error_count++;
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    // misses and held answers keep i_stall_f2 high so the answer waits for the driver
    task automatic fetch(input addr_t addr, input bit nc, input int hold, input string name);
        bit hit;
        hit = lookup(addr, nc);
        exp_name.push_back(name);
        exp_word.push_back(mem_word(addr));
        exp_hit.push_back(hit);
        exp_addr.push_back(nc ? {addr[31:2], 2'b00} : {addr[31:5], 5'b0});
        exp_len.push_back(nc ? 8'd0 : 8'd7);
        @(posedge clk);
        inst_en   <= 1'b1;
        inst_addr <= addr;
        no_cache  <= nc;
        stall_f2  <= 1'b0;
        if (!hit || hold != 0) begin
            @(posedge clk);
            stall_f2 <= 1'b1;
            if (!hit) begin
                do begin
                    @(posedge clk);
                end while (stall);
            end
            repeat (hold) @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            pending = 1'b0;
            xfers = 0;
            beats = 0;
            stalls = 0;
        end else begin
            if (arvalid && arready) begin
                if (exp_word.size() == 0) begin
                    abort("address transfer seen with no request outstanding");
                end else begin
                    check($sformatf("%s araddr", exp_name[0]), exp_addr[0], araddr);
                    check($sformatf("%s arlen", exp_name[0]), exp_len[0], arlen);
                    check($sformatf("%s arsize", exp_name[0]), WORD_SIZE, arsize);
                    xfers++;
                end
            end
            if (rvalid && rready) begin
                beats++;
            end
            if (pending && stall) begin
                stalls++;
            end else if (pending) begin
                if (exp_word.size() == 0) begin
                    abort("answer seen with no request outstanding");
                end else begin
                    check(exp_name[0], exp_word[0], inst_rdata);
                    if (!stall_f2) begin
                        check($sformatf("%s transfers", exp_name[0]), exp_hit[0] ? 0 : 1,
                              xfers);
                        check($sformatf("%s beats", exp_name[0]),
                              exp_hit[0] ? 0 : exp_len[0] + 1, beats);
                        if (exp_hit[0]) begin
                            check($sformatf("%s stall cycles", exp_name[0]), 0, stalls);
                        end
                        void'(exp_name.pop_front());
                        void'(exp_word.pop_front());
                        void'(exp_addr.pop_front());
                        void'(exp_len.pop_front());
                        void'(exp_hit.pop_front());
                        xfers = 0;
                        beats = 0;
                        stalls = 0;
                    end
                end
            end
            if (!stall_f2 || stall) begin
                pending = inst_en;
            end
        end
    end

    initial begin
        repeat (NR_REQUESTS * 80) @(posedge clk);
        $display("timeout, the cache stopped answering requests");
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        addr_t addr;
        bit    nc;
        int    hold;
        seed = 7;
        error_count = 0;
        rst = 1'b1;
        inst_en = 1'b0;
        inst_addr = '0;
        no_cache = 1'b0;
        stall_f2 = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        fetch(32'h0000_1234, 1'b0, 0, "cold miss");
        for (int i = 0; i < 8; i++) begin
            fetch(32'h0000_1220 + 4 * i, 1'b0, 0, "hit");
        end

        // three tags on set 9
        fetch(32'h0001_0128, 1'b0, 0, "lru a");
        fetch(32'h0002_0124, 1'b0, 0, "lru b");
        fetch(32'h0001_0128, 1'b0, 0, "lru a");
        fetch(32'h0003_013C, 1'b0, 0, "lru c");
        fetch(32'h0001_0128, 1'b0, 0, "lru a again");
        fetch(32'h0002_0124, 1'b0, 0, "lru b again");

        fetch(32'h0000_4A58, 1'b1, 0, "uncached");
        fetch(32'h0000_4A58, 1'b0, 0, "cached after uncached");
        fetch(32'h0000_1234, 1'b1, 0, "uncached on cached line");

        for (int i = 0; i < BP_REQUESTS; i++) begin
            addr = 32'h0000_1200 + (($random(seed) & 15) << 2);
            hold = 1 + ($random(seed) & 3);
            fetch(addr, 1'b0, hold, "back-pressure");
        end

        // four tags over four sets, so lines get evicted often
        for (int i = 0; i < RANDOM_REQUESTS; i++) begin
            addr = $random(seed) & 32'h0000_307C;
            nc = ($random(seed) & 7) == 0;
            hold = 0;
            if (($random(seed) & 7) == 0) begin
                hold = 1 + ($random(seed) & 3);
            end
            fetch(addr, nc, hold, "random");
        end

        @(posedge clk);
        inst_en  <= 1'b0;
        stall_f2 <= 1'b0;
        while (exp_word.size() != 0) begin
            @(posedge clk);
        end
        repeat (16) @(posedge clk);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
rtl/icache_pkg.sv
rtl/icache_beat_counter.sv
rtl/icache_tag_store.sv
rtl/icache_data_bank.sv
rtl/icache_refill_fsm.sv
rtl/icache.sv
bench/axi_mem_model.sv
bench/tb_icache.sv
